// ==== verilog/issue_pkg.sv ====
package issue_pkg;

    localparam int PIPE_WIDTH  = 2;  // CDB ports, 0 = local ALU, 1 = external unit
    localparam int DQ_DEPTH    = 2;
    localparam int MUL_LATENCY = 3;  // Issue to result, in cycles
    localparam int DQ_PTR_W    = $clog2(DQ_DEPTH);
    localparam int MUL_CNT_W   = $clog2(MUL_LATENCY);

    typedef logic [4:0]            tag_t;
    typedef logic [31:0]           data_t;
    typedef logic [DQ_PTR_W-1:0]   dq_ptr_t;
    typedef logic [DQ_PTR_W:0]     dq_cnt_t;
    typedef logic [MUL_CNT_W-1:0]  mul_cnt_t;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,  // Signed compare
        MUL   // Low 32 bits of product
    } uop_e;

    typedef struct packed {
        logic  is_renamed;  // Data not valid yet, waiting on tag
        tag_t  tag;
        data_t data;
    } operand_t;

    typedef struct packed {
        logic     is_valid;
        tag_t     dest_tag;
        operand_t src_a;
        operand_t src_b;
        uop_e     uop;
    } instruction_t;

    typedef struct packed {
        logic  is_valid;
        tag_t  dest_tag;
        data_t result;
    } writeback_packet_t;

    // Later ports overwrite earlier ones, so the highest matching index wins
    function automatic operand_t cdb_capture(input operand_t op,
                                             input writeback_packet_t cdb [PIPE_WIDTH]);
        operand_t res;
        res = op;
        for (int i = 0; i < PIPE_WIDTH; i++) begin
            if (op.is_renamed && cdb[i].is_valid && (cdb[i].dest_tag == op.tag)) begin
                res.is_renamed = 1'b0;
                res.data       = cdb[i].result;
            end
        end
        return res;
    endfunction

    function automatic instruction_t insn_capture(input instruction_t insn,
                                                  input writeback_packet_t cdb [PIPE_WIDTH]);
        instruction_t res;
        res       = insn;
        res.src_a = cdb_capture(insn.src_a, cdb);
        res.src_b = cdb_capture(insn.src_b, cdb);
        return res;
    endfunction

endpackage

// ==== verilog/dispatch_queue.sv ====
`timescale 1ns/1ps

module dispatch_queue (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush_i,
    input  issue_pkg::instruction_t      dispatch_i,
    input  logic                         disp_we_i,
    input  issue_pkg::writeback_packet_t cdb_i [issue_pkg::PIPE_WIDTH],
    input  logic                         accept_i,
    output logic                         disp_rdy_o,
    output issue_pkg::instruction_t      head_o,
    output logic                         head_valid_o
);
    import issue_pkg::*;

    instruction_t entries [DQ_DEPTH];  // Payload only, validity comes from count
    dq_ptr_t      rd_ptr;
    dq_ptr_t      wr_ptr;
    dq_cnt_t      count;
    logic         wr_en;
    logic         pop;

    assign disp_rdy_o   = (count != dq_cnt_t'(DQ_DEPTH));
    assign head_valid_o = (count != '0);
    assign head_o       = entries[rd_ptr];

    assign wr_en = disp_we_i && dispatch_i.is_valid && disp_rdy_o;
    assign pop   = accept_i && head_valid_o;

    // Stored operands snoop the CDB every cycle, new ones on the way in
    always_ff @(posedge clk) begin
        for (int i = 0; i < DQ_DEPTH; i++) begin
            if (wr_en && (wr_ptr == dq_ptr_t'(i))) begin
                entries[i] <= insn_capture(dispatch_i, cdb_i);
            end else begin
                entries[i] <= insn_capture(entries[i], cdb_i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == dq_ptr_t'(DQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == dq_ptr_t'(DQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

// ==== verilog/rs.sv ====
`timescale 1ns/1ps

module rs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush_i,
    input  logic                         stall_i,
    input  issue_pkg::instruction_t      rs_entry_i,
    input  logic                         rs_we_i,
    input  logic                         alu_re_i,
    input  issue_pkg::writeback_packet_t cdb_i [issue_pkg::PIPE_WIDTH],
    output logic                         rs_write_rdy_o,
    output logic                         rs_read_rdy_o,
    output logic                         accept_o,
    output issue_pkg::instruction_t      execute_pkt_o
);
    import issue_pkg::*;

    typedef enum logic {
        IDLE,
        PASS_THRU
    } rs_state_e;

    rs_state_e state;
    rs_state_e next_state;
    logic      srcs_ready;
    logic      issue;
    logic      drain;  // Issue with nothing behind it

    assign srcs_ready = !execute_pkt_o.src_a.is_renamed && !execute_pkt_o.src_b.is_renamed;

    always_comb begin
        rs_write_rdy_o = 1'b0;
        rs_read_rdy_o  = 1'b0;
        issue          = 1'b0;
        case (state)
            IDLE: begin
                rs_write_rdy_o = 1'b1;
            end
            PASS_THRU: begin
                if (srcs_ready) begin
                    rs_read_rdy_o = 1'b1;
                    if (alu_re_i) begin
                        issue          = 1'b1;
                        rs_write_rdy_o = 1'b1;  // Slot frees this cycle
                    end
                end
            end
            default: begin
                rs_write_rdy_o = 1'b0;
            end
        endcase
    end

    assign accept_o = rs_we_i && rs_entry_i.is_valid && rs_write_rdy_o && !stall_i;
    assign drain    = issue && !accept_o;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      next_state = accept_o ? PASS_THRU : IDLE;
            PASS_THRU: begin
                if (drain) begin
                    next_state = IDLE;
                end
            end
            default:   next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Held entry, with late operands taken off the CDB
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            execute_pkt_o <= '0;
        end else if (accept_o) begin
            execute_pkt_o <= insn_capture(rs_entry_i, cdb_i);  // Catches same-cycle results
        end else if (drain) begin
            execute_pkt_o <= '0;
        end else begin
            execute_pkt_o <= insn_capture(execute_pkt_o, cdb_i);
        end
    end

endmodule

// ==== verilog/int_alu.sv ====
`timescale 1ns/1ps

module int_alu (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush_i,
    input  issue_pkg::instruction_t      issue_pkt_i,
    input  logic                         read_rdy_i,
    output logic                         alu_re_o,
    output issue_pkg::writeback_packet_t wb_o
);
    import issue_pkg::*;

    logic     issue;
    logic     mul_busy;
    mul_cnt_t mul_cnt;
    tag_t     mul_tag;
    data_t    mul_prod;
    data_t    op_a;
    data_t    op_b;
    data_t    alu_res;

    assign alu_re_o = read_rdy_i && !mul_busy;  // Multiply in flight holds the rs
    assign issue    = alu_re_o;

    assign op_a = issue_pkt_i.src_a.data;
    assign op_b = issue_pkt_i.src_b.data;

    always_comb begin
        case (issue_pkt_i.uop)
            ADD:     alu_res = op_a + op_b;
            SUB:     alu_res = op_a - op_b;
            AND:     alu_res = op_a & op_b;
            OR:      alu_res = op_a | op_b;
            XOR:     alu_res = op_a ^ op_b;
            SLT:     alu_res = data_t'($signed(op_a) < $signed(op_b));
            MUL:     alu_res = op_a * op_b;  // Low word only
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            mul_busy    <= 1'b0;
            mul_cnt     <= '0;
            wb_o.is_valid <= 1'b0;
        end else begin
            wb_o.is_valid <= 1'b0;  // One-cycle pulse per result
            if (mul_busy) begin
                mul_cnt <= mul_cnt - 1'b1;
                if (mul_cnt == mul_cnt_t'(1)) begin
                    mul_busy      <= 1'b0;
                    wb_o.is_valid <= 1'b1;
                    wb_o.dest_tag <= mul_tag;
                    wb_o.result   <= mul_prod;
                end
            end else if (issue && (issue_pkt_i.uop == MUL)) begin
                mul_busy <= 1'b1;
                mul_cnt  <= mul_cnt_t'(MUL_LATENCY - 1);
                mul_tag  <= issue_pkt_i.dest_tag;
                mul_prod <= alu_res;
            end else if (issue) begin
                wb_o.is_valid <= 1'b1;
                wb_o.dest_tag <= issue_pkt_i.dest_tag;
                wb_o.result   <= alu_res;
            end
        end
    end

endmodule

// ==== verilog/issue_slice.sv ====
`timescale 1ns/1ps

module issue_slice (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush_i,
    input  logic                         stall_i,
    input  issue_pkg::instruction_t      dispatch_i,
    input  logic                         disp_we_i,
    input  issue_pkg::writeback_packet_t ext_wb_i,
    output logic                         disp_rdy_o,
    output issue_pkg::writeback_packet_t wb_o
);
    import issue_pkg::*;

    writeback_packet_t cdb [PIPE_WIDTH];
    instruction_t      rs_entry;
    instruction_t      execute_pkt;
    logic              rs_we;
    logic              accept;
    logic              rs_read_rdy;
    logic              alu_re;

    assign cdb[0] = wb_o;      // Local ALU
    assign cdb[1] = ext_wb_i;  // Unit outside the slice

    dispatch_queue u_dq (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .dispatch_i   (dispatch_i),
        .disp_we_i    (disp_we_i),
        .cdb_i        (cdb),
        .accept_i     (accept),
        .disp_rdy_o   (disp_rdy_o),
        .head_o       (rs_entry),
        .head_valid_o (rs_we)
    );

    rs u_rs (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (flush_i),
        .stall_i        (stall_i),
        .rs_entry_i     (rs_entry),
        .rs_we_i        (rs_we),
        .alu_re_i       (alu_re),
        .cdb_i          (cdb),
        .rs_write_rdy_o (),
        .rs_read_rdy_o  (rs_read_rdy),
        .accept_o       (accept),
        .execute_pkt_o  (execute_pkt)
    );

    int_alu u_alu (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush_i),
        .issue_pkt_i (execute_pkt),
        .read_rdy_i  (rs_read_rdy),
        .alu_re_o    (alu_re),
        .wb_o        (wb_o)
    );

endmodule

// ==== tb/issue_slice_assert.sv ====
`timescale 1ns/1ps

module issue_slice_assert (
    input logic                    clk,
    input logic                    rst,
    input logic                    flush_i,
    input logic                    issue_i,
    input logic                    accept_i,
    input logic                    read_rdy_i,
    input issue_pkg::instruction_t pkt_i
);
    import issue_pkg::*;

    // Only a valid entry with every operand in hand is offered to the ALU
    ready_no_rename: assert property (@(posedge clk)
        read_rdy_i |-> pkt_i.is_valid && !pkt_i.src_a.is_renamed && !pkt_i.src_b.is_renamed)
        else $error("rs_read_rdy high without a valid entry or with a renamed operand");

    no_issue_in_reset: assert property (@(posedge clk) rst |-> !issue_i)
        else $error("rs issued while in reset");

    // Back-to-back handoff keeps the successor
    accept_keeps_entry: assert property (@(posedge clk)
        issue_i && accept_i && !rst && !flush_i |=> pkt_i.is_valid)
        else $error("rs lost the entry accepted during an issue");

    hold_keeps_entry: assert property (@(posedge clk)
        pkt_i.is_valid && !issue_i && !rst && !flush_i |=> pkt_i.is_valid)
        else $error("rs dropped a held entry that never issued");

endmodule

bind rs issue_slice_assert u_rs_assert (
    .clk        (clk),
    .rst        (rst),
    .flush_i    (flush_i),
    .issue_i    (issue),
    .accept_i   (accept_o),
    .read_rdy_i (rs_read_rdy_o),
    .pkt_i      (execute_pkt_o)
);

// ==== tb/tb_issue_slice.sv ====
`timescale 1ns/1ps

module tb_issue_slice;
    import issue_pkg::*;

    localparam int TIMEOUT = 50;  // Cycles per wait

    logic              clk;
    logic              rst;
    logic              flush_i;
    logic              stall_i;
    instruction_t      dispatch_i;
    logic              disp_we_i;
    writeback_packet_t ext_wb_i;
    logic              disp_rdy_o;
    writeback_packet_t wb_o;

    tag_t  exp_tag_q [$];  // Results still owed, in dispatch order
    data_t exp_res_q [$];
    logic  saw_full;
    logic  run_ended;

    issue_slice dut_i (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (flush_i),
        .stall_i    (stall_i),
        .dispatch_i (dispatch_i),
        .disp_we_i  (disp_we_i),
        .ext_wb_i   (ext_wb_i),
        .disp_rdy_o (disp_rdy_o),
        .wb_o       (wb_o)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        run_ended = 1'b1;
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic data_t model_result(input uop_e uop, input data_t a, input data_t b);
        case (uop)
            ADD:     return a + b;
            SUB:     return a + ~b + 32'd1;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return (a[31] != b[31]) ? data_t'(a[31]) : data_t'(a < b);
            MUL:     return data_t'(64'(a) * 64'(b));
            default: return '0;
        endcase
    endfunction

    function automatic operand_t ready_src(input data_t d);
        return '{is_renamed: 1'b0, tag: '0, data: d};
    endfunction

    function automatic operand_t waiting_src(input tag_t t);
        return '{is_renamed: 1'b1, tag: t, data: 32'hdead_beef};  // Junk until woken
    endfunction

    function automatic instruction_t make_op(input uop_e u, input tag_t dest,
                                             input operand_t a, input operand_t b);
        return '{is_valid: 1'b1, dest_tag: dest, src_a: a, src_b: b, uop: u};
    endfunction

    // Writes at the next rising edge, leaves disp_we_i high for bursts
    task automatic send_op(input instruction_t op, input logic owed, input data_t res);
        int waited;
        waited = 0;
        while (!disp_rdy_o) begin
            disp_we_i = 1'b0;
            saw_full  = 1'b1;
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timed out waiting for disp_rdy_o");
                abort_run();
            end
        end
        dispatch_i = op;
        disp_we_i  = 1'b1;
        if (owed) begin
            exp_tag_q.push_back(op.dest_tag);
            exp_res_q.push_back(res);
        end
        @(negedge clk);
    endtask

    task automatic send_ready(input uop_e u, input tag_t dest, input data_t a, input data_t b);
        send_op(make_op(u, dest, ready_src(a), ready_src(b)), 1'b1, model_result(u, a, b));
    endtask

    task automatic idle_inputs(input int cycles);
        disp_we_i           = 1'b0;
        dispatch_i.is_valid = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_res_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timed out with %0d results never written back", exp_res_q.size());
                abort_run();
            end
        end
    endtask

    task automatic broadcast_ext(input tag_t tag, input data_t value);
        ext_wb_i = '{is_valid: 1'b1, dest_tag: tag, result: value};
        @(negedge clk);
        ext_wb_i.is_valid = 1'b0;
    endtask

    // Every wb_o pulse must match the oldest owed result
    always @(negedge clk) begin
        if (!rst && wb_o.is_valid) begin
            if (exp_res_q.size() == 0) begin
                $display("Unexpected wb_o pulse for tag %h", wb_o.dest_tag);
                abort_run();
            end else begin
                check_hex("wb_o.dest_tag", 32'(wb_o.dest_tag), 32'(exp_tag_q[0]));
                check_hex("wb_o.result", wb_o.result, exp_res_q[0]);
                void'(exp_tag_q.pop_front());
                void'(exp_res_q.pop_front());
            end
        end
    end

    task automatic test_reset();
        check_hex("disp_rdy_o", 32'(disp_rdy_o), 32'h1);
        idle_inputs(5);  // Monitor catches any stray pulse
    endtask

    task automatic test_ready_ops();
        int lat;
        send_ready(ADD, 5'd8, $urandom, $urandom);
        idle_inputs(0);
        lat = 1;
        while (!wb_o.is_valid) begin
            @(negedge clk);
            lat++;
            if (lat > TIMEOUT) begin
                $display("Timed out waiting for the first result");
                abort_run();
            end
        end
        check_hex("write to wb_o latency", 32'(lat), 32'd3);
        wait_drain();
        for (int k = 0; k < 6; k++) begin
            send_ready(uop_e'(k), tag_t'(9 + k), $urandom, $urandom);
        end
        idle_inputs(0);
        wait_drain();
    endtask

    task automatic test_ext_wakeup();
        data_t v;
        data_t b;
        v = $urandom;
        b = $urandom;
        send_op(make_op(XOR, 5'd12, waiting_src(5'd20), ready_src(b)), 1'b1, v ^ b);
        idle_inputs(6);
        check_hex("owed results before wakeup", 32'(exp_res_q.size()), 32'd1);
        broadcast_ext(5'd20, v);
        wait_drain();
    endtask

    task automatic test_local_forward();
        data_t a;
        data_t b;
        data_t c;
        data_t r;
        a = $urandom;
        b = $urandom;
        c = $urandom;
        r = model_result(ADD, a, b);
        send_ready(ADD, 5'd3, a, b);
        send_op(make_op(SUB, 5'd5, waiting_src(5'd3), ready_src(c)), 1'b1, r - c);
        // Second dependent sits in the queue while the multiply runs
        r = model_result(MUL, a, c);
        send_ready(MUL, 5'd4, a, c);
        send_op(make_op(AND, 5'd6, waiting_src(5'd4), ready_src(b)), 1'b1, r & b);
        send_op(make_op(OR, 5'd7, ready_src(c), waiting_src(5'd4)), 1'b1, c | r);
        idle_inputs(0);
        wait_drain();
    endtask

    task automatic test_mul_burst();
        saw_full = 1'b0;
        for (int i = 0; i < 6; i++) begin
            send_ready((i % 2 == 0) ? MUL : ADD, tag_t'(16 + i), $urandom, $urandom);
        end
        idle_inputs(0);
        wait_drain();
        assert (saw_full) else begin
            $display("disp_rdy_o never fell during the multiply burst");
            abort_run();
        end
    endtask

    task automatic test_flush();
        send_op(make_op(ADD, 5'd10, waiting_src(5'd9), ready_src($urandom)), 1'b0, '0);
        idle_inputs(3);
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        broadcast_ext(5'd9, $urandom);
        idle_inputs(6);
        send_ready(SLT, 5'd11, $urandom, $urandom);
        idle_inputs(0);
        wait_drain();
    endtask

    initial begin
        void'($urandom(32'h6e12310a));
        clk        = 1'b0;
        rst        = 1'b1;
        flush_i    = 1'b0;
        stall_i    = 1'b0;
        dispatch_i = '0;
        disp_we_i  = 1'b0;
        ext_wb_i   = '0;
        saw_full   = 1'b0;
        run_ended  = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_ready_ops();
        test_ext_wakeup();
        test_local_forward();
        test_mul_burst();
        test_flush();
        run_ended = 1'b1;
        $display("TESTS PASSED");
        $finish;
    end

    // A bound assertion can stop the run before the tests finish
    final begin
        if (!run_ended) begin
            $display("TESTS FAILED");
        end
    end

endmodule

// ==== compile.f ====
verilog/issue_pkg.sv
verilog/dispatch_queue.sv
verilog/rs.sv
verilog/int_alu.sv
verilog/issue_slice.sv
tb/issue_slice_assert.sv
tb/tb_issue_slice.sv

// ==== Makefile ====
TOP := tb_issue_slice

all: run

run:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o sim
	./obj_dir/sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
